//--- Makefile
TOP := tb_i2s_pkt_rx
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): verilog.f $(wildcard rtl/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: $(BIN)
	-$(BIN) > sim.log 2>&1
	@cat sim.log
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/apb_rx_port.sv
`timescale 1ns/100ps

module apb_rx_port
	import rx_pkt_pkg::*;
#(
	parameter int FIFO_DEPTH = 32,
	localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
	input  logic             bclk,
	input  logic             rst_n,
	input  apb_req_t         apb_req,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	input  fifo_entry_t      head,
	input  logic             empty,
	input  logic [LVL_W-1:0] level,
	input  logic             overflow,
	output logic             pop
);

	logic access;
	logic rd_data;
	logic rd_status;
	logic wr_status;
	logic error_full;
	logic error_empty;

	// Access phase only, setup phase is ignored
	assign access = apb_req.psel && apb_req.penable;
	assign rd_data = access && !apb_req.pwrite && (apb_req.paddr == ADDR_DATA);
	assign rd_status = access && !apb_req.pwrite && (apb_req.paddr == ADDR_STATUS);
	assign wr_status = access && apb_req.pwrite && (apb_req.paddr == ADDR_STATUS);

	assign pready = 1'b1; // No wait states
	assign pop = rd_data && !empty;
	assign pslverr = rd_data && empty;

	always_comb begin
		prdata = '0;
		if (rd_data && !empty) begin
			prdata = 32'(head);
		end else if (rd_status) begin
			prdata = {29'd0, error_empty, error_full, level != '0};
		end
	end

	// Sticky status bits
	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			error_full <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			if (wr_status) begin // Write data is don't care
				error_full <= 1'b0;
				error_empty <= 1'b0;
			end
			if (overflow)
				error_full <= 1'b1;
			if (pslverr)
				error_empty <= 1'b1;
		end
	end

endmodule

//--- rtl/i2s_link_pkg.sv
package i2s_link_pkg;

	// Serial side of the link

	localparam int SLOT_BITS = 24; // Bits taken per I2S slot
	localparam int WORD_BITS = 16;
	localparam int BYTE_BITS = 8;
	localparam int WORD_BYTES = WORD_BITS / BYTE_BITS;

	typedef logic [SLOT_BITS-1:0] slot_t; // MSB first on the wire
	typedef logic [WORD_BITS-1:0] word_t; // Upper part of a slot
	typedef logic [BYTE_BITS-1:0] byte_t;

	// One word per valid pulse
	typedef struct packed {
		logic  valid;
		word_t word;
	} word_strobe_t;

endpackage

//--- rtl/i2s_pkt_rx_top.sv
`timescale 1ns/100ps

module i2s_pkt_rx_top
	import i2s_link_pkg::*;
	import rx_pkt_pkg::*;
#(
	parameter stream_id_t STREAM_ID = '0,
	parameter int FIFO_DEPTH = 32
) (
	input  logic        bclk,
	input  logic        rst_n,
	input  logic        lrclk,
	input  logic        sdata,
	input  apb_req_t    apb_req,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

	word_strobe_t     word_s;
	logic             pay_load;
	payload_t         payload;
	logic             wr_en;
	fifo_entry_t      wr_entry;
	fifo_entry_t      head;
	logic             empty;
	logic [LVL_W-1:0] level;
	logic             overflow;
	logic             pop;

	//////////////////////////////////////////////////////////////////////
	// Input side and processing
	//////////////////////////////////////////////////////////////////////

	i2s_slot_deserializer i2s_slot_deserializer_inst (
		.bclk(bclk), .rst_n(rst_n), .lrclk(lrclk), .sdata(sdata), .word_out(word_s));

	pkt_frame_matcher pkt_frame_matcher_inst (
		.bclk(bclk), .rst_n(rst_n), .word_in(word_s), .pay_load(pay_load), .payload(payload));

	payload_unloader #(.STREAM_ID(STREAM_ID)) payload_unloader_inst (
		.bclk(bclk), .rst_n(rst_n), .pay_load(pay_load), .payload(payload),
		.wr_en(wr_en), .wr_entry(wr_entry));

	//////////////////////////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////////////////////////

	tagged_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tagged_fifo_inst (
		.bclk(bclk), .rst_n(rst_n), .wr_en(wr_en), .wr_entry(wr_entry), .pop(pop),
		.head(head), .empty(empty), .level(level), .overflow(overflow));

	apb_rx_port #(.FIFO_DEPTH(FIFO_DEPTH)) apb_rx_port_inst (
		.bclk(bclk), .rst_n(rst_n), .apb_req(apb_req), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .head(head), .empty(empty), .level(level),
		.overflow(overflow), .pop(pop));

endmodule

//--- rtl/i2s_slot_deserializer.sv
`timescale 1ns/100ps

module i2s_slot_deserializer
	import i2s_link_pkg::*;
(
	input  logic         bclk,
	input  logic         rst_n,
	input  logic         lrclk,
	input  logic         sdata,
	output word_strobe_t word_out
);

	logic       lrclk_q;
	logic       lr_edge;
	logic       active;    // Slot bits still to come
	logic [4:0] bit_cnt;
	logic       last_bit;
	slot_t      shift_q;
	slot_t      slot_next;
	logic       word_valid;
	word_t      word_q;

	assign lr_edge = lrclk ^ lrclk_q;
	assign slot_next = {shift_q[SLOT_BITS-2:0], sdata};
	assign last_bit = active && !lr_edge && (bit_cnt == 5'(SLOT_BITS - 1));

	// Plain sampler for edge detection
	always_ff @(posedge bclk) begin
		lrclk_q <= lrclk;
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			active <= 1'b0;
			bit_cnt <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= last_bit;
			if (lr_edge) begin
				active <= 1'b1; // MSB arrives one bclk later
				bit_cnt <= '0;
			end else if (active) begin
				bit_cnt <= bit_cnt + 5'd1;
				if (last_bit)
					active <= 1'b0; // Rest of the slot is ignored
			end
		end
	end

	always_ff @(posedge bclk) begin
		if (active && !lr_edge)
			shift_q <= slot_next;
		if (last_bit)
			word_q <= slot_next[SLOT_BITS-1 -: WORD_BITS];
	end

	assign word_out = '{valid: word_valid, word: word_q};

	// Edge, one idle bit, 24 data bits, then the strobe
	a_word_after_edge: assert property (@(posedge bclk) disable iff (!rst_n)
		word_valid |-> $past(lrclk, 25) != $past(lrclk, 26));

endmodule

//--- rtl/payload_unloader.sv
`timescale 1ns/100ps

module payload_unloader
	import i2s_link_pkg::*;
	import rx_pkt_pkg::*;
#(
	parameter stream_id_t STREAM_ID = '0
) (
	input  logic        bclk,
	input  logic        rst_n,
	input  logic        pay_load,
	input  payload_t    payload,
	output logic        wr_en,
	output fifo_entry_t wr_entry
);

	payload_t      pay_buf;
	unload_state_t state;
	logic [3:0]    idx;      // 0 is the oldest byte
	byte_t         cur_byte;

	assign cur_byte = pay_buf[(PAY_BYTES - 1 - int'(idx)) * BYTE_BITS +: BYTE_BITS];
	assign wr_en = state == SHIFT;
	assign wr_entry = '{pad: 3'b000, id: STREAM_ID, data: cur_byte};

	always_ff @(posedge bclk) begin
		if (state == IDLE && pay_load)
			pay_buf <= payload;
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (pay_load) begin
						state <= SHIFT;
						idx <= '0;
					end
				end
				SHIFT: begin // pay_load is not looked at here
					idx <= idx + 4'd1;
					if (idx == 4'(PAY_BYTES - 1))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_burst_length: assert property (@(posedge bclk) disable iff (!rst_n)
		$rose(wr_en) |-> wr_en [*PAY_BYTES] ##1 !wr_en);

endmodule

//--- rtl/pkt_frame_matcher.sv
`timescale 1ns/100ps

module pkt_frame_matcher
	import i2s_link_pkg::*;
	import rx_pkt_pkg::*;
(
	input  logic         bclk,
	input  logic         rst_n,
	input  word_strobe_t word_in,
	output logic         pay_load,
	output payload_t     payload  // Last payload passed on
);

	localparam int PAY_W = $bits(payload_t);
	localparam int HDR_W = HDR_BYTES * BYTE_BITS;

	payload_t     window;   // Last 15 stream bytes
	match_state_t state;
	pkg_count_t   byte_cnt;
	pkg_count_t   cnt_next;
	logic         hdr_hit;
	logic         pkg_end;  // Final word is in the window

	//////////////////////////////////////////////////////////////////////
	// Byte window
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge bclk) begin
		if (word_in.valid)
			window <= {window[PAY_W-WORD_BITS-1:0], word_in.word}; // High byte is older
	end

	// Window still holds the previous words here
	assign hdr_hit = window[HDR_W-1:0] == PKT_HEADER;
	assign cnt_next = byte_cnt + pkg_count_t'(WORD_BYTES);

	//////////////////////////////////////////////////////////////////////
	// Header hunt and package count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			state <= HUNT;
			byte_cnt <= '0;
			pkg_end <= 1'b0;
			pay_load <= 1'b0;
			payload <= '0;
		end else begin
			pkg_end <= 1'b0;
			pay_load <= 1'b0;
			case (state)
				HUNT: begin
					if (word_in.valid && hdr_hit) begin
						state <= COUNT;
						byte_cnt <= pkg_count_t'(HDR_BYTES + WORD_BYTES); // Header plus this word
					end
				end
				COUNT: begin
					if (pkg_end) begin
						state <= HUNT;
						byte_cnt <= '0;
						// Repeats of the same payload are dropped
						if (window != payload) begin
							payload <= window;
							pay_load <= 1'b1;
						end
					end else if (word_in.valid) begin
						byte_cnt <= cnt_next;
						if (cnt_next == pkg_count_t'(PKG_BYTES))
							pkg_end <= 1'b1;
					end
				end
				default: begin
					state <= HUNT;
				end
			endcase
		end
	end

	a_count_in_range: assert property (@(posedge bclk) disable iff (!rst_n)
		byte_cnt <= pkg_count_t'(PKG_BYTES));

endmodule

//--- rtl/rx_pkt_pkg.sv
package rx_pkt_pkg;
	import i2s_link_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Packet format
	//////////////////////////////////////////////////////////////////////

	localparam int HDR_BYTES = 10;
	localparam int PKG_BYTES = 174; // Header included
	localparam int PAY_BYTES = 15;  // Tail of the package

	// First byte on the wire sits in the top byte
	localparam logic [HDR_BYTES*BYTE_BITS-1:0] PKT_HEADER = 80'h0B77_A1DD_4240_2F84_2B03;

	typedef logic [4:0] stream_id_t;
	typedef logic [7:0] pkg_count_t; // Bytes seen in a package
	typedef logic [PAY_BYTES*BYTE_BITS-1:0] payload_t; // Oldest byte on top

	typedef struct packed {
		logic [2:0] pad;
		stream_id_t id;
		byte_t      data;
	} fifo_entry_t;

	typedef enum logic {HUNT, COUNT} match_state_t;
	typedef enum logic {IDLE, SHIFT} unload_state_t;

	//////////////////////////////////////////////////////////////////////
	// Host bus
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	localparam logic [7:0] ADDR_DATA = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;

endpackage

//--- rtl/tagged_fifo.sv
`timescale 1ns/100ps

module tagged_fifo
	import rx_pkt_pkg::*;
#(
	parameter int FIFO_DEPTH = 32,
	localparam int PTR_W = $clog2(FIFO_DEPTH),
	localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
	input  logic             bclk,
	input  logic             rst_n,
	input  logic             wr_en,
	input  fifo_entry_t      wr_entry,
	input  logic             pop,
	output fifo_entry_t      head,
	output logic             empty,
	output logic [LVL_W-1:0] level,
	output logic             overflow
);

	fifo_entry_t      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             do_wr;

	assign full = level == LVL_W'(FIFO_DEPTH);
	assign empty = level == '0;
	assign do_wr = wr_en && !full; // Writes into a full buffer are lost
	assign head = mem[rd_ptr];     // No read latency

	always_ff @(posedge bclk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge bclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= wr_en && full;
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: ;
			endcase
		end
	end

	// The APB port only pops a non-empty buffer
	a_no_pop_empty: assert property (@(posedge bclk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

//--- verif/tb_i2s_source.svh
`ifndef TB_I2S_SOURCE_SVH
`define TB_I2S_SOURCE_SVH

// Header bytes in wire order
localparam byte_t HDR_SEQ [HDR_BYTES] = '{8'h0B, 8'h77, 8'hA1, 8'hDD, 8'h42,
	8'h40, 8'h2F, 8'h84, 8'h2B, 8'h03};

// One 32 bclk slot, lrclk change then 24 bits MSB first
task automatic send_slot(input word_t w);
	slot_t s;
	s = {w, 8'h00};
	@(negedge bclk);
	lrclk = ~lrclk;
	sdata = 1'b0;
	for (int i = SLOT_BITS - 1; i >= 0; i--) begin
		@(negedge bclk);
		sdata = s[i];
	end
	repeat (32 - SLOT_BITS - 1) begin
		@(negedge bclk);
		sdata = 1'b0;
	end
endtask

task automatic send_idle(input int n);
	repeat (n) send_slot('0);
endtask

// New random bytes from index first to the end of the fill
task automatic make_fill(input int first);
	for (int i = first; i < FILL_BYTES; i++) begin
		fill[i] = 8'($random(seed));
	end
endtask

task automatic send_package(input logic bad_hdr);
	byte_t pkg [PKG_BYTES];
	for (int i = 0; i < HDR_BYTES; i++) begin
		pkg[i] = HDR_SEQ[i];
	end
	if (bad_hdr)
		pkg[4] = pkg[4] ^ 8'h10; // One header byte off
	for (int i = 0; i < FILL_BYTES; i++) begin
		pkg[HDR_BYTES + i] = fill[i];
	end
	send_idle(4);
	for (int k = 0; k < PKG_BYTES; k += 2) begin
		send_slot({pkg[k], pkg[k + 1]}); // High byte first
	end
	send_idle(4);
endtask

// Package bytes 159 to 173, as many as the FIFO can hold
task automatic expect_payload();
	for (int i = PKG_BYTES - PAY_BYTES; i < PKG_BYTES; i++) begin
		if (exp_q.size() < FIFO_DEPTH)
			exp_q.push_back(fill[i - HDR_BYTES]);
	end
endtask

`endif

//--- verif/tb_i2s_pkt_rx.sv
`timescale 1ns/100ps

module tb_i2s_pkt_rx
	import i2s_link_pkg::*;
	import rx_pkt_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int FIFO_DEPTH = 32;
	localparam stream_id_t TB_STREAM_ID = 5'd9;
	localparam int FILL_BYTES = PKG_BYTES - HDR_BYTES;
	localparam int NUM_PKGS = 8; // Packages sent over all tests
	localparam int WATCHDOG_NS = NUM_PKGS * 200 * 32 * CLK_PERIOD + 100_000;

	logic        bclk;
	logic        rst_n;
	logic        lrclk;
	logic        sdata;
	apb_req_t    apb_req;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	byte_t  fill [FILL_BYTES]; // Package bytes after the header
	byte_t  exp_q [$];
	integer seed;

	`include "tb_i2s_source.svh"

	i2s_pkt_rx_top #(.STREAM_ID(TB_STREAM_ID), .FIFO_DEPTH(FIFO_DEPTH)) i2s_pkt_rx_top_inst (
		.bclk(bclk), .rst_n(rst_n), .lrclk(lrclk), .sdata(sdata), .apb_req(apb_req),
		.prdata(prdata), .pready(pready), .pslverr(pslverr));

	initial begin
		bclk = 1'b0;
		forever #(CLK_PERIOD / 2) bclk = ~bclk;
	end

	initial begin
		#(WATCHDOG_NS);
		report_fail("Timeout: the tests did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compare_entry(input string name, input fifo_entry_t got,
		input fifo_entry_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic compare_status(input string name, input logic [2:0] got,
		input logic [2:0] exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB host
	//////////////////////////////////////////////////////////////////////

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge bclk);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(negedge bclk);
		apb_req.penable = 1'b1;
		#(CLK_PERIOD / 4); // Sample ahead of the rising edge
		data = prdata;
		err = pslverr;
		compare_flag("pready", pready, 1'b1);
		@(negedge bclk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		@(negedge bclk);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: wdata};
		@(negedge bclk);
		apb_req.penable = 1'b1;
		@(negedge bclk);
		apb_req = '0;
	endtask

	task automatic check_status(input logic [2:0] exp);
		logic [31:0] data;
		logic        err;
		apb_read(ADDR_STATUS, data, err);
		compare_flag("pslverr", err, 1'b0);
		compare_flag("status_upper_zero", data[31:3] == '0, 1'b1);
		compare_status("status", data[2:0], exp);
	endtask

	task automatic read_entry();
		logic [31:0] data;
		logic        err;
		fifo_entry_t exp;
		exp = '{pad: 3'b000, id: TB_STREAM_ID, data: exp_q.pop_front()};
		apb_read(ADDR_DATA, data, err);
		compare_flag("pslverr", err, 1'b0);
		compare_flag("prdata_upper_zero", data[31:16] == '0, 1'b1);
		compare_entry("prdata", fifo_entry_t'(data[15:0]), exp);
	endtask

	task automatic empty_read();
		logic [31:0] data;
		logic        err;
		apb_read(ADDR_DATA, data, err);
		compare_flag("pslverr", err, 1'b1);
		compare_flag("prdata_upper_zero", data[31:16] == '0, 1'b1);
		compare_entry("prdata", fifo_entry_t'(data[15:0]), '0);
	endtask

	// Polls the not-empty bit
	task automatic wait_not_empty();
		logic [31:0] data;
		logic        err;
		int          polls;
		polls = 0;
		apb_read(ADDR_STATUS, data, err);
		while (!data[0]) begin
			if (polls == 200) begin
				report_fail("No FIFO entry arrived after the package was sent");
			end else begin
				polls++;
				apb_read(ADDR_STATUS, data, err);
			end
		end
	endtask

	task automatic drain_fifo();
		while (exp_q.size() != 0)
			read_entry();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_and_empty_read();
		check_status(3'b000);
		empty_read();
		check_status(3'b100);
		apb_write(ADDR_STATUS, 32'd0);
		check_status(3'b000);
	endtask

	task automatic single_package_payload();
		make_fill(0);
		send_package(1'b0);
		expect_payload();
		wait_not_empty();
		drain_fifo();
		check_status(3'b000);
	endtask

	task automatic repeat_package_suppressed();
		send_package(1'b0);
		check_status(3'b000); // Same payload is not passed on
		make_fill(FILL_BYTES - PAY_BYTES);
		send_package(1'b0);
		expect_payload();
		wait_not_empty();
		drain_fifo();
		check_status(3'b000);
	endtask

	task automatic bad_header_ignored();
		make_fill(0);
		send_package(1'b1);
		check_status(3'b000);
		send_package(1'b0);
		expect_payload();
		wait_not_empty();
		drain_fifo();
		check_status(3'b000);
	endtask

	task automatic overflow_sets_error_full();
		repeat (3) begin
			make_fill(0);
			send_package(1'b0);
			expect_payload();
		end
		wait_not_empty();
		check_status(3'b011);
		drain_fifo();
		empty_read();
		check_status(3'b110); // error_full stays until a status write
	endtask

	initial begin
		seed = 32'hadd2;
		rst_n = 1'b0;
		lrclk = 1'b0;
		sdata = 1'b0;
		apb_req = '0;
		repeat (8) @(negedge bclk);
		rst_n = 1'b1;
		reset_and_empty_read();
		single_package_payload();
		repeat_package_suppressed();
		bad_header_ignored();
		overflow_sets_error_full();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verif
rtl/i2s_link_pkg.sv
rtl/rx_pkt_pkg.sv
rtl/i2s_slot_deserializer.sv
rtl/pkt_frame_matcher.sv
rtl/payload_unloader.sv
rtl/tagged_fifo.sv
rtl/apb_rx_port.sv
rtl/i2s_pkt_rx_top.sv
verif/tb_i2s_pkt_rx.sv
